/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_lsu
FILELIST   = sim.f
OBJ_DIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf $(OBJ_DIR)

/* logic/axil_if.sv */
interface axil_if;
    import lsu_pkg::*;

    logic [31:0] araddr;
    logic        arvalid, arready;
    logic [31:0] rdata;
    resp_e       rresp;
    logic        rvalid, rready;
    logic [31:0] awaddr;
    logic        awvalid, awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid, wready;
    resp_e       bresp;
    logic        bvalid, bready;

    modport master (
        output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

    modport slave (
        input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
    );

endinterface

/* logic/clint_dev.sv */
module clint_dev (
    input  logic  clk,
    input  logic  rst_n,
    axil_if.slave bus
);
    import lsu_pkg::*;

    logic [63:0] mtime;
    logic        ar_hs;

    assign bus.arready = ~bus.rvalid;
    assign bus.awready = ~bus.bvalid;
    assign bus.wready  = ~bus.bvalid;
    assign bus.rresp   = resp_okay;
    assign bus.bresp   = resp_okay;

    assign ar_hs = bus.arvalid & bus.arready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime      <= 64'd0;
            bus.rvalid <= 1'b0;
            bus.bvalid <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (ar_hs)                         bus.rvalid <= 1'b1;
            else if (bus.rvalid && bus.rready) bus.rvalid <= 1'b0;
            // writes are acked and dropped
            if (bus.wvalid && bus.wready)      bus.bvalid <= 1'b1;
            else if (bus.bvalid && bus.bready) bus.bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) bus.rdata <= bus.araddr[2] ? mtime[63:32] : mtime[31:0]; // +4 is high word
    end

endmodule

/* logic/lsu.sv */
module lsu (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           issue,
    input  logic           wen,
    input  logic           ren,
    input  logic           sign,
    input  lsu_pkg::size_e size,
    input  logic [31:0]    addr,
    input  logic [31:0]    wdata,
    output logic [31:0]    rdata,
    output logic           done,
    axil_if.master         bus
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {st_idle, st_addr, st_data, st_resp} state_e;

    state_e      state;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;
    size_e       size_q;
    logic        sign_q;
    logic        done_q;
    logic        accept;
    logic [31:0] store_lane;
    logic [3:0]  store_strb;
    logic [31:0] load_shift;
    logic [31:0] load_ext;

    assign accept = issue && (state == st_idle);

    // store data moved up to its byte lane
    assign store_lane = wdata << {addr[1:0], 3'b000};

    always_comb begin
        case (size)
            size_byte: store_strb = 4'b0001 << addr[1:0];
            size_half: store_strb = addr[1] ? 4'b1100 : 4'b0011;
            size_word: store_strb = 4'b1111;
            default:   store_strb = 4'b0000;
        endcase
    end

    assign load_shift = bus.rdata >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (size_q)
            size_byte: load_ext = {{24{load_shift[7] & sign_q}}, load_shift[7:0]};
            size_half: load_ext = {{16{load_shift[15] & sign_q}}, load_shift[15:0]};
            size_word: load_ext = load_shift;
            default:   load_ext = 32'd0;
        endcase
    end

    assign bus.araddr = addr_q;
    assign bus.awaddr = addr_q;
    assign bus.wdata  = wdata_q;
    assign bus.wstrb  = wstrb_q;

    // done goes straight back when there is no bus access
    assign done = done_q | (accept & ~wen & ~ren);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_idle;
            bus.arvalid <= 1'b0;
            bus.awvalid <= 1'b0;
            bus.wvalid  <= 1'b0;
            bus.rready  <= 1'b0;
            bus.bready  <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept && (wen || ren)) begin
                        state <= st_addr;
                        if (wen) bus.awvalid <= 1'b1; // store wins
                        else     bus.arvalid <= 1'b1;
                    end
                end
                st_addr: begin
                    if (bus.arvalid && bus.arready) begin
                        bus.arvalid <= 1'b0;
                        bus.rready  <= 1'b1;
                        state       <= st_resp;
                    end
                    if (bus.awvalid && bus.awready) begin
                        bus.awvalid <= 1'b0;
                        bus.wvalid  <= 1'b1;
                        state       <= st_data;
                    end
                end
                st_data: begin
                    if (bus.wvalid && bus.wready) begin
                        bus.wvalid <= 1'b0;
                        bus.bready <= 1'b1;
                        state      <= st_resp;
                    end
                end
                default: begin
                    if ((bus.rvalid && bus.rready) || (bus.bvalid && bus.bready)) begin
                        bus.rready <= 1'b0;
                        bus.bready <= 1'b0;
                        done_q     <= 1'b1;
                        state      <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= addr;
            wdata_q <= store_lane;
            wstrb_q <= store_strb;
            size_q  <= size;
            sign_q  <= sign;
        end
        if (bus.rvalid && bus.rready) rdata <= load_ext; // held until next load
    end

endmodule

/* logic/lsu_pkg.sv */
package lsu_pkg;

    // device address map
    localparam logic [31:0] dev_serial_addr = 32'ha000_03f8;
    localparam logic [31:0] dev_clint_base  = 32'ha000_0048;
    localparam logic [31:0] dev_clint_end   = 32'ha000_004f;

    // same encoding as the core's mask field
    typedef enum logic [1:0] {
        size_none = 2'b00,
        size_byte = 2'b01,
        size_half = 2'b10,
        size_word = 2'b11
    } size_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_e;

endpackage

/* logic/lsu_top.sv */
module lsu_top #(
    parameter int SRAM_AW = 10
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           issue,
    input  logic           wen,
    input  logic           ren,
    input  logic           sign,
    input  lsu_pkg::size_e size,
    input  logic [31:0]    addr,
    input  logic [31:0]    wdata,
    output logic [31:0]    rdata,
    output logic           done,
    output logic [7:0]     uart_tx_data,
    output logic           uart_tx_valid
);

    axil_if cpu_bus ();
    axil_if sram_bus ();
    axil_if uart_bus ();
    axil_if clint_bus ();

    lsu u_lsu (
        .clk   (clk),
        .rst_n (rst_n),
        .issue (issue),
        .wen   (wen),
        .ren   (ren),
        .sign  (sign),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .bus   (cpu_bus.master)
    );

    lsu_xbar u_xbar (
        .upstream (cpu_bus.slave),
        .sram     (sram_bus.master),
        .uart     (uart_bus.master),
        .clint    (clint_bus.master)
    );

    sram_dev #(.SRAM_AW(SRAM_AW)) u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (sram_bus.slave)
    );

    uart_dev u_uart (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (uart_bus.slave),
        .tx_data  (uart_tx_data),
        .tx_valid (uart_tx_valid)
    );

    clint_dev u_clint (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (clint_bus.slave)
    );

endmodule

/* logic/lsu_xbar.sv */
module lsu_xbar (
    axil_if.slave  upstream,
    axil_if.master sram,
    axil_if.master uart,
    axil_if.master clint
);
    import lsu_pkg::*;

    localparam logic [1:0] sel_sram  = 2'd0;
    localparam logic [1:0] sel_uart  = 2'd1;
    localparam logic [1:0] sel_clint = 2'd2;

    logic [1:0] rd_sel;
    logic [1:0] wr_sel;

    // anything unmapped lands in the sram
    function automatic logic [1:0] decode(input logic [31:0] a);
        if (a == dev_serial_addr) return sel_uart;
        if (a >= dev_clint_base && a <= dev_clint_end) return sel_clint;
        return sel_sram;
    endfunction

    assign rd_sel = decode(upstream.araddr);
    assign wr_sel = decode(upstream.awaddr);

    assign sram.araddr  = upstream.araddr;
    assign uart.araddr  = upstream.araddr;
    assign clint.araddr = upstream.araddr;
    assign sram.awaddr  = upstream.awaddr;
    assign uart.awaddr  = upstream.awaddr;
    assign clint.awaddr = upstream.awaddr;
    assign sram.wdata   = upstream.wdata;
    assign uart.wdata   = upstream.wdata;
    assign clint.wdata  = upstream.wdata;
    assign sram.wstrb   = upstream.wstrb;
    assign uart.wstrb   = upstream.wstrb;
    assign clint.wstrb  = upstream.wstrb;

    // valids and readies only reach the selected device
    assign sram.arvalid  = upstream.arvalid && (rd_sel == sel_sram);
    assign uart.arvalid  = upstream.arvalid && (rd_sel == sel_uart);
    assign clint.arvalid = upstream.arvalid && (rd_sel == sel_clint);
    assign sram.rready   = upstream.rready && (rd_sel == sel_sram);
    assign uart.rready   = upstream.rready && (rd_sel == sel_uart);
    assign clint.rready  = upstream.rready && (rd_sel == sel_clint);
    assign sram.awvalid  = upstream.awvalid && (wr_sel == sel_sram);
    assign uart.awvalid  = upstream.awvalid && (wr_sel == sel_uart);
    assign clint.awvalid = upstream.awvalid && (wr_sel == sel_clint);
    assign sram.wvalid   = upstream.wvalid && (wr_sel == sel_sram);
    assign uart.wvalid   = upstream.wvalid && (wr_sel == sel_uart);
    assign clint.wvalid  = upstream.wvalid && (wr_sel == sel_clint);
    assign sram.bready   = upstream.bready && (wr_sel == sel_sram);
    assign uart.bready   = upstream.bready && (wr_sel == sel_uart);
    assign clint.bready  = upstream.bready && (wr_sel == sel_clint);

    always_comb begin
        case (rd_sel)
            sel_uart: begin
                upstream.arready = uart.arready;
                upstream.rdata   = uart.rdata;
                upstream.rresp   = uart.rresp;
                upstream.rvalid  = uart.rvalid;
            end
            sel_clint: begin
                upstream.arready = clint.arready;
                upstream.rdata   = clint.rdata;
                upstream.rresp   = clint.rresp;
                upstream.rvalid  = clint.rvalid;
            end
            default: begin
                upstream.arready = sram.arready;
                upstream.rdata   = sram.rdata;
                upstream.rresp   = sram.rresp;
                upstream.rvalid  = sram.rvalid;
            end
        endcase
    end

    always_comb begin
        case (wr_sel)
            sel_uart: begin
                upstream.awready = uart.awready;
                upstream.wready  = uart.wready;
                upstream.bresp   = uart.bresp;
                upstream.bvalid  = uart.bvalid;
            end
            sel_clint: begin
                upstream.awready = clint.awready;
                upstream.wready  = clint.wready;
                upstream.bresp   = clint.bresp;
                upstream.bvalid  = clint.bvalid;
            end
            default: begin
                upstream.awready = sram.awready;
                upstream.wready  = sram.wready;
                upstream.bresp   = sram.bresp;
                upstream.bvalid  = sram.bvalid;
            end
        endcase
    end

endmodule

/* logic/sram_dev.sv */
module sram_dev #(
    parameter int SRAM_AW = 10
) (
    input  logic  clk,
    input  logic  rst_n,
    axil_if.slave bus
);
    import lsu_pkg::*;

    logic [31:0]        mem [2**SRAM_AW];
    logic [SRAM_AW-1:0] rd_idx;
    logic [SRAM_AW-1:0] wr_idx;
    logic               ar_hs;
    logic               aw_hs;
    logic               w_hs;

    assign rd_idx = bus.araddr[SRAM_AW+1:2]; // word index without the byte offset

    assign bus.arready = ~bus.rvalid;
    assign bus.awready = ~bus.bvalid;
    assign bus.wready  = ~bus.bvalid;
    assign bus.rresp   = resp_okay;
    assign bus.bresp   = resp_okay;

    assign ar_hs = bus.arvalid & bus.arready;
    assign aw_hs = bus.awvalid & bus.awready;
    assign w_hs  = bus.wvalid & bus.wready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.rvalid <= 1'b0;
            bus.bvalid <= 1'b0;
        end else begin
            if (ar_hs)                         bus.rvalid <= 1'b1;
            else if (bus.rvalid && bus.rready) bus.rvalid <= 1'b0;
            if (w_hs)                          bus.bvalid <= 1'b1;
            else if (bus.bvalid && bus.bready) bus.bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) bus.rdata <= mem[rd_idx];
        if (aw_hs) wr_idx <= bus.awaddr[SRAM_AW+1:2];
        if (w_hs) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.wstrb[i]) mem[wr_idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
            end
        end
    end

endmodule

/* logic/uart_dev.sv */
module uart_dev (
    input  logic       clk,
    input  logic       rst_n,
    axil_if.slave      bus,
    output logic [7:0] tx_data,
    output logic       tx_valid
);
    import lsu_pkg::*;

    logic w_hs;
    logic [7:0] lane_byte;

    assign bus.arready = ~bus.rvalid;
    assign bus.awready = ~bus.bvalid;
    assign bus.wready  = ~bus.bvalid;
    assign bus.rdata   = 32'd0; // no receiver
    assign bus.rresp   = resp_okay;
    assign bus.bresp   = resp_okay;

    assign w_hs = bus.wvalid & bus.wready;

    // lowest strobed lane
    always_comb begin
        if (bus.wstrb[0])      lane_byte = bus.wdata[7:0];
        else if (bus.wstrb[1]) lane_byte = bus.wdata[15:8];
        else if (bus.wstrb[2]) lane_byte = bus.wdata[23:16];
        else                   lane_byte = bus.wdata[31:24];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_valid   <= 1'b0;
            bus.rvalid <= 1'b0;
            bus.bvalid <= 1'b0;
        end else begin
            tx_valid <= w_hs;
            if (bus.arvalid && bus.arready)    bus.rvalid <= 1'b1;
            else if (bus.rvalid && bus.rready) bus.rvalid <= 1'b0;
            if (w_hs)                          bus.bvalid <= 1'b1;
            else if (bus.bvalid && bus.bready) bus.bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (w_hs) tx_data <= lane_byte;
    end

endmodule

/* sim.f */
logic/lsu_pkg.sv
logic/axil_if.sv
logic/lsu.sv
logic/lsu_xbar.sv
logic/sram_dev.sv
logic/uart_dev.sv
logic/clint_dev.sv
logic/lsu_top.sv
tb/lsu_checker.sv
tb/tb_lsu.sv

/* tb/lsu_checker.sv */
module lsu_checker (
    input logic clk,
    input logic rst_n,
    input logic done,
    input logic arvalid,
    input logic arready,
    input logic awvalid,
    input logic awready,
    input logic wvalid
);

    // address valids stay up until taken
    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(arvalid) |-> $past(arready))
        else $error("arvalid dropped before its handshake");

    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(awvalid) |-> $past(awready))
        else $error("awvalid dropped before its handshake");

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done high for more than one cycle");

    // write data only after the address went through
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wvalid) |-> $past(awvalid && awready))
        else $error("wvalid rose without a preceding aw handshake");

endmodule

bind lsu lsu_checker i_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .done    (done),
    .arvalid (bus.arvalid),
    .arready (bus.arready),
    .awvalid (bus.awvalid),
    .awready (bus.awready),
    .wvalid  (bus.wvalid)
);

/* tb/lsu_stimulus.txt */
# name op size sign addr wdata expected   (size 1 byte, 2 half, 3 word; addr/data/expected hex)
# expected is the load result, the serial byte for serial writes, unused for other writes
word_wr0     write 3 0 00000100 12345678 00000000
word_rd0     read  3 0 00000100 00000000 12345678
word_wr1     write 3 0 00000104 a5b6c7d8 00000000
byte_wr1     write 1 0 00000105 000000e1 00000000
half_wr1     write 2 0 00000106 00009f3c 00000000
merge_rd1    read  3 0 00000104 00000000 9f3ce1d8
byte_rd_o0_z read  1 0 00000104 00000000 000000d8
byte_rd_o1_s read  1 1 00000105 00000000 ffffffe1
byte_rd_o2_s read  1 1 00000106 00000000 0000003c
byte_rd_o3_z read  1 0 00000107 00000000 0000009f
byte_rd_o3_s read  1 1 00000107 00000000 ffffff9f
half_rd_o0_s read  2 1 00000104 00000000 ffffe1d8
half_rd_o2_z read  2 0 00000106 00000000 00009f3c
half_rd_o2_s read  2 1 00000106 00000000 ffff9f3c
byte_rd_o2_z read  1 0 00000102 00000000 00000034
mtime_lo0    mtime 3 0 a0000048 00000000 00000000
mtime_hi     mtime 3 0 a000004c 00000000 00000000
shadow_wr    write 3 0 000003f8 cafef00d 00000000
serial_wr    write 3 0 a00003f8 00000041 00000041
serial_wr_b  write 1 0 a00003f8 0000005a 0000005a
shadow_rd    read  3 0 000003f8 00000000 cafef00d
noop         none  3 0 00000100 deadbeef 00000000
noop_rd      read  3 0 00000100 00000000 12345678
mtime_lo1    mtime 3 0 a0000048 00000000 00000000

/* tb/tb_lsu.sv */
module tb_lsu;
    import lsu_pkg::*;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        issue;
    logic        wen;
    logic        ren;
    logic        sign;
    size_e       size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        done;
    logic [7:0]  uart_tx_data;
    logic        uart_tx_valid;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 0;
    string       lines[$];
    logic [7:0]  tx_q[$];
    logic [31:0] model [logic [29:0]]; // sram words written so far

    lsu_top #(.SRAM_AW(10)) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue         (issue),
        .wen           (wen),
        .ren           (ren),
        .sign          (sign),
        .size          (size),
        .addr          (addr),
        .wdata         (wdata),
        .rdata         (rdata),
        .done          (done),
        .uart_tx_data  (uart_tx_data),
        .uart_tx_valid (uart_tx_valid)
    );

    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && uart_tx_valid) tx_q.push_back(uart_tx_data);
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic load_stimulus();
        int          fd;
        int          rc;
        string       line;
        string       name;
        string       op;
        int          sz;
        int          sg;
        logic [31:0] a;
        logic [31:0] wd;
        logic [31:0] ex;
        fd = $fopen("tb/lsu_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tb/lsu_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                // comment lines never parse to all seven fields
                if (rc > 0 && $sscanf(line, "%s %s %d %d %h %h %h",
                                      name, op, sz, sg, a, wd, ex) == 7)
                    lines.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    // merged word after a store by the byte strobe rule
    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] a,
                                                input logic [31:0] d, input int sz);
        logic [3:0]  strb;
        logic [31:0] lane;
        logic [31:0] res;
        case (sz)
            1:       strb = 4'b0001 << a[1:0];
            2:       strb = 4'b0011 << a[1:0];
            default: strb = 4'b1111;
        endcase
        lane = d << (8 * a[1:0]);
        for (int i = 0; i < 4; i++)
            res[i*8 +: 8] = strb[i] ? lane[i*8 +: 8] : old[i*8 +: 8];
        return res;
    endfunction

    task automatic run_access(input string op, input int sz, input int sg,
                              input logic [31:0] a, input logic [31:0] wd);
        logic got;
        @(posedge clk); // one idle cycle between accesses
        @(posedge clk);
        #1;
        issue = 1'b1;
        wen   = (op == "write");
        ren   = (op == "read") || (op == "mtime");
        sign  = sg[0];
        size  = size_e'(sz[1:0]);
        addr  = a;
        wdata = wd;
        @(negedge clk);
        got = done; // no-op access finishes here
        @(posedge clk);
        #1;
        issue = 1'b0;
        wen   = 1'b0;
        ren   = 1'b0;
        while (!got) begin
            @(negedge clk);
            got = done;
        end
    endtask

    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("timeout after %0d cycles, an access never finished", cycles);
        finish_run();
    end

    initial begin
        string       name;
        string       op;
        int          sz;
        int          sg;
        logic [31:0] a;
        logic [31:0] wd;
        logic [31:0] ex;
        logic [31:0] old;
        logic [31:0] last_mtime;
        rst_n      = 1'b0;
        issue      = 1'b0;
        wen        = 1'b0;
        ren        = 1'b0;
        sign       = 1'b0;
        size       = size_none;
        addr       = 32'd0;
        wdata      = 32'd0;
        last_mtime = 32'd0;
        load_stimulus();
        limit = 40 * lines.size() + 10;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s %s %d %d %h %h %h", name, op, sz, sg, a, wd, ex));
            run_access(op, sz, sg, a, wd);
            if (op == "write") begin
                if (a == dev_serial_addr) begin
                    if (tx_q.size() != 1) begin
                        errors++;
                        $display("%s: expected one serial byte, saw %0d", name, tx_q.size());
                    end else begin
                        check(name, ex, {24'd0, tx_q.pop_front()});
                    end
                end else begin
                    if (tx_q.size() != 0) begin
                        errors++;
                        $display("%s: serial byte sent by a memory store", name);
                    end
                    old = model.exists(a[31:2]) ? model[a[31:2]] : 32'hx;
                    model[a[31:2]] = merge_store(old, a, wd, sz);
                end
                tx_q.delete();
            end else if (op == "read") begin
                check(name, ex, rdata);
                if (sz == 3 && model.exists(a[31:2]))
                    check({name, "_model"}, model[a[31:2]], rdata);
            end else if (op == "mtime") begin
                if (a[2]) begin
                    check(name, ex, rdata);
                end else begin
                    if (rdata <= last_mtime) begin
                        errors++;
                        $display("%s: mtime did not increase (%h after %h)",
                                 name, rdata, last_mtime);
                    end
                    last_mtime = rdata;
                end
            end else if (op != "none") begin
                errors++;
                $display("%s: unknown operation %s in stimulus", name, op);
            end
        end
        finish_run();
    end

endmodule
